// ==== build.f ====
verilog/tmu_pkg.sv
verilog/tmu_vertex_sort.sv
verilog/tmu_edgedivops.sv
verilog/tmu_edgediv.sv
verilog/tmu_edge_setup.sv
testbench/tb_tmu_edge_setup.sv

// ==== testbench/tmu_edge_cases.txt ====
# a_sx a_sy a_dx a_dy  b_sx b_sy b_dx b_dy  c_sx c_sy c_dx c_dy  then nine quotients
# (edge 1 dx du dv, edge 2 dx du dv, edge 3 dx du dv)  then divisors of edge 1, 2, 3
0 0 0 0  10 20 30 10  40 50 60 30  3 1 2 2 1 1 1 1 1  10 30 20
0 0 0 0  40 50 60 30  10 20 30 10  3 1 2 2 1 1 1 1 1  10 30 20
10 20 30 10  0 0 0 0  40 50 60 30  3 1 2 2 1 1 1 1 1  10 30 20
10 20 30 10  40 50 60 30  0 0 0 0  3 1 2 2 1 1 1 1 1  10 30 20
40 50 60 30  0 0 0 0  10 20 30 10  3 1 2 2 1 1 1 1 1  10 30 20
40 50 60 30  10 20 30 10  0 0 0 0  3 1 2 2 1 1 1 1 1  10 30 20
20 -90 -300 100  100 -50 -200 -100  -30 80 50 -40  4 2 2 0 0 0 2 0 1  60 200 140
5 5 10 20  25 -15 -90 20  0 0 0 50  100 20 20 0 0 0 3 0 0  1 30 30
30 60 90 40  0 0 0 -10  -60 -30 -120 40  1 0 1 2 1 0 0 0 0  50 50 1
1 2 3 7  11 -8 33 7  -4 6 -17 7  30 10 10 0 0 0 0 0 0  1 1 1
-500 1000 900 1000  1000 500 1000 0  -1000 -1000 -1000 -1000  2 2 1 0 0 1 0 1 0  1000 2000 1000
0 0 0 0  -3 4 -5 3  7 -9 300 1  300 7 9 1 1 1 152 5 6  1 3 2
2 3 4 5  6 7 8 5  9 10 11 0  1 1 1 0 0 0 0 0 0  5 5 1
-77 333 250 37  640 -12 -800 511  123 -456 -321 -200  2 0 3 0 0 0 2 1 0  237 711 474
50 50 50 -500  50 50 50 -499  50 50 50 -497  0 0 0 0 0 0 0 0 0  1 3 2
0 0 0 1020  1023 -1023 -1023 1000  -1023 1023 1023 -1000  1 1 1 0 0 0 51 51 51  2000 2020 20
0 0 -7 0  21 0 0 7  0 14 7 14  1 3 0 1 0 1 1 3 2  7 14 7
-1 -1 -1 -1  -2 -2 -2 -2  -3 -3 -3 -3  1 1 1 1 1 1 1 1 1  1 2 1
1000 -1000 -1000 9  0 0 0 0  100 200 300 3  100 33 66 111 111 111 216 150 200  3 9 6

// ==== testbench/tb_tmu_edge_setup.sv ====
`timescale 1ns/1ps

module tb_tmu_edge_setup;

	localparam int MAX_CASES = 64;
	localparam int WAIT_LIMIT = 2000;
	localparam int DRAIN_CYCLES = 20;

	logic sys_clk;
	logic sys_rst;
	logic pipe_stb_i;
	logic pipe_ack_o;
	tmu_pkg::tmu_triangle_t tri_i;
	logic pipe_stb_o;
	logic pipe_ack_i;
	tmu_pkg::tmu_div_result_t result_o;
	logic busy_o;

	// Per case 12 coordinates, 9 quotients and 3 divisors
	int case_val[MAX_CASES][24];
	int num_cases;

	// Reference model results
	int ref_pos[MAX_CASES][9];
	int ref_mag[MAX_CASES][9];
	int ref_div[MAX_CASES][3];
	// Sorted A src x, y, A dst x, y, B dst y, C dst y
	int ref_pt[MAX_CASES][6];

	int seed;
	int err_count;
	int pass_count;
	int fail_count;
	bit timed_out;

	tmu_edge_setup tmu_edge_setup_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.tri_i(tri_i),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.result_o(result_o),
		.busy_o(busy_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	task automatic load_cases();
		int fd;
		int cnt;
		int val;
		int pos;
		logic [8*256-1:0] junk;
		num_cases = 0;
		pos = 0;
		fd = $fopen("testbench/tmu_edge_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open testbench/tmu_edge_cases.txt");
			err_count++;
			return;
		end
		while (!$feof(fd) && num_cases < MAX_CASES) begin
			cnt = $fscanf(fd, "%d", val);
			if (cnt == 1) begin
				case_val[num_cases][pos] = val;
				pos++;
				if (pos == 24) begin
					pos = 0;
					num_cases++;
				end
			end else if (cnt == 0) begin
				// Comment line so the rest of it is skipped
				cnt = $fgets(junk, fd);
			end else begin
				break;
			end
		end
		$fclose(fd);
		if (pos != 0) begin
			$display("Case file ends with an incomplete line");
			err_count++;
		end
	endtask

	// Stable sort on destination Y then deltas and divisors per edge
	task automatic build_reference(input int idx);
		int v[3][4];
		int tmp;
		int from_i;
		int to_i;
		int col;
		int span;
		int diff;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 4; j++)
				v[i][j] = case_val[idx][4*i+j];
		for (int p = 0; p < 2; p++)
			for (int i = 0; i < 2; i++)
				if (v[i+1][3] < v[i][3]) begin
					for (int j = 0; j < 4; j++) begin
						tmp = v[i][j];
						v[i][j] = v[i+1][j];
						v[i+1][j] = tmp;
					end
				end
		for (int e = 0; e < 3; e++) begin
			// Edges A-B, A-C, B-C
			from_i = (e == 2) ? 1 : 0;
			to_i = (e == 0) ? 1 : 2;
			span = v[to_i][3] - v[from_i][3];
			ref_div[idx][e] = (span == 0) ? 1 : span;
			for (int c = 0; c < 3; c++) begin
				// dx from dst x, du from src x, dv from src y
				col = (c == 0) ? 2 : ((c == 1) ? 0 : 1);
				diff = v[to_i][col] - v[from_i][col];
				ref_pos[idx][3*e+c] = (diff > 0) ? 1 : 0;
				ref_mag[idx][3*e+c] = (diff < 0) ? -diff : diff;
				// Flat edges 2 and 3 carry no dividend
				if (span == 0 && e != 0)
					ref_mag[idx][3*e+c] = 0;
			end
		end
		for (int j = 0; j < 4; j++)
			ref_pt[idx][j] = v[0][j];
		ref_pt[idx][4] = v[1][3];
		ref_pt[idx][5] = v[2][3];
	endtask

	function automatic tmu_pkg::tmu_vertex_t make_vertex(input int idx, input int n);
		tmu_pkg::tmu_vertex_t vx;
		vx.src.x = 12'(case_val[idx][4*n]);
		vx.src.y = 12'(case_val[idx][4*n+1]);
		vx.dst.x = 12'(case_val[idx][4*n+2]);
		vx.dst.y = 12'(case_val[idx][4*n+3]);
		return vx;
	endfunction

	task automatic report_mismatch(input int idx, input string field, input int got,
		input int exp);
		$display("[ERROR] time %0t: case %0d %s got %0d expected %0d",
			$time, idx, field, got, exp);
	endtask

	task automatic check_result(input int idx, output int errs);
		int q;
		int r;
		int d;
		int k;
		errs = 0;
		for (int e = 0; e < 3; e++) begin
			d = result_o.divisor[e];
			if (d != case_val[idx][21+e]) begin
				report_mismatch(idx, $sformatf("divisor[%0d]", e), d, case_val[idx][21+e]);
				errs++;
			end
			for (int c = 0; c < 3; c++) begin
				k = 3*e + c;
				q = result_o.quotient[k];
				r = result_o.remainder[k];
				if (result_o.positive[k] != ref_pos[idx][k]) begin
					report_mismatch(idx, $sformatf("positive[%0d]", k),
						result_o.positive[k], ref_pos[idx][k]);
					errs++;
				end
				if (q != case_val[idx][12+k]) begin
					report_mismatch(idx, $sformatf("quotient[%0d]", k), q, case_val[idx][12+k]);
					errs++;
				end
				if (r >= ref_div[idx][e]) begin
					$display("[ERROR] time %0t: case %0d remainder[%0d] = %0d not below divisor %0d",
						$time, idx, k, r, ref_div[idx][e]);
					errs++;
				end
				// Quotient and remainder must rebuild the magnitude
				if (q * ref_div[idx][e] + r != ref_mag[idx][k]) begin
					report_mismatch(idx, $sformatf("q*d+r[%0d]", k), q * ref_div[idx][e] + r,
						ref_mag[idx][k]);
					errs++;
				end
			end
		end
		if ($signed(result_o.a_src.x) != ref_pt[idx][0]) begin
			report_mismatch(idx, "a_src.x", $signed(result_o.a_src.x), ref_pt[idx][0]);
			errs++;
		end
		if ($signed(result_o.a_src.y) != ref_pt[idx][1]) begin
			report_mismatch(idx, "a_src.y", $signed(result_o.a_src.y), ref_pt[idx][1]);
			errs++;
		end
		if ($signed(result_o.a_dst.x) != ref_pt[idx][2]) begin
			report_mismatch(idx, "a_dst.x", $signed(result_o.a_dst.x), ref_pt[idx][2]);
			errs++;
		end
		if ($signed(result_o.a_dst.y) != ref_pt[idx][3]) begin
			report_mismatch(idx, "a_dst.y", $signed(result_o.a_dst.y), ref_pt[idx][3]);
			errs++;
		end
		if ($signed(result_o.b_dst_y) != ref_pt[idx][4]) begin
			report_mismatch(idx, "b_dst_y", $signed(result_o.b_dst_y), ref_pt[idx][4]);
			errs++;
		end
		if ($signed(result_o.c_dst_y) != ref_pt[idx][5]) begin
			report_mismatch(idx, "c_dst_y", $signed(result_o.c_dst_y), ref_pt[idx][5]);
			errs++;
		end
	endtask

	// One triangle in and held until the input acknowledge
	task automatic send_case(input int idx);
		int waited;
		tmu_pkg::tmu_triangle_t t;
		t.a = make_vertex(idx, 0);
		t.b = make_vertex(idx, 1);
		t.c = make_vertex(idx, 2);
		@(posedge sys_clk);
		pipe_stb_i <= 1'b1;
		tri_i <= t;
		waited = 0;
		@(negedge sys_clk);
		while (!pipe_ack_o && !timed_out && waited < WAIT_LIMIT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!pipe_ack_o && !timed_out) begin
			$display("Timeout: case %0d was never accepted by the DUT", idx);
			timed_out = 1'b1;
		end
		// Transfer edge
		@(posedge sys_clk);
		pipe_stb_i <= 1'b0;
	endtask

	task automatic drive_all();
		for (int i = 0; i < num_cases && !timed_out; i++)
			send_case(i);
	endtask

	// Random output stalls with each result checked once and watched while held
	task automatic collect_results();
		int out_idx;
		int waited;
		int errs;
		int case_errs;
		int stall_left;
		bit holding;
		tmu_pkg::tmu_div_result_t held;
		out_idx = 0;
		waited = 0;
		case_errs = 0;
		stall_left = 0;
		holding = 1'b0;
		while (out_idx < num_cases && !timed_out) begin
			@(posedge sys_clk);
			if (stall_left > 0) begin
				pipe_ack_i <= 1'b0;
				stall_left--;
			end else if (($random(seed) & 3) == 0) begin
				pipe_ack_i <= 1'b0;
				stall_left = $random(seed) & 7;
			end else begin
				pipe_ack_i <= 1'b1;
			end
			@(negedge sys_clk);
			waited++;
			if (pipe_stb_o) begin
				if (!holding) begin
					check_result(out_idx, errs);
					case_errs += errs;
					held = result_o;
					holding = 1'b1;
				end else if (result_o !== held) begin
					$display("[ERROR] time %0t: case %0d result changed while not acknowledged",
						$time, out_idx);
					case_errs++;
				end
				// Acknowledge seen now completes on the next edge
				if (pipe_ack_i) begin
					if (case_errs == 0) begin
						$display("Case %0d passed", out_idx);
						pass_count++;
					end else begin
						$display("Case %0d failed with %0d errors", out_idx, case_errs);
						fail_count++;
					end
					err_count += case_errs;
					case_errs = 0;
					holding = 1'b0;
					waited = 0;
					out_idx++;
				end
			end
			if (waited > WAIT_LIMIT) begin
				$display("Timeout: no result came out for case %0d", out_idx);
				timed_out = 1'b1;
			end
		end
	endtask

	// After the last case nothing more may come out
	task automatic drain_check();
		int extra;
		extra = 0;
		@(posedge sys_clk);
		pipe_ack_i <= 1'b1;
		repeat (DRAIN_CYCLES) begin
			@(negedge sys_clk);
			if (pipe_stb_o)
				extra++;
		end
		if (extra != 0 || busy_o) begin
			$display("Drain check failed: %0d extra strobe cycles, busy %0b", extra, busy_o);
			fail_count++;
			err_count++;
		end else begin
			$display("Drain check passed");
			pass_count++;
		end
	endtask

	initial begin
		seed = 20247;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		sys_rst = 1'b1;
		pipe_stb_i = 1'b0;
		pipe_ack_i = 1'b0;
		tri_i = '0;
		load_cases();
		for (int i = 0; i < num_cases; i++)
			build_reference(i);
		repeat (3) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(negedge sys_clk);
		if (pipe_stb_o || busy_o || !pipe_ack_o) begin
			$display("Reset check failed: stb %0b busy %0b ack %0b", pipe_stb_o, busy_o,
				pipe_ack_o);
			fail_count++;
			err_count++;
		end else begin
			$display("Reset check passed");
			pass_count++;
		end
		fork
			drive_all();
			collect_results();
		join
		if (!timed_out)
			drain_check();
		$display("Summary: %0d tests passed, %0d tests failed, %0d errors, %0d cases read",
			pass_count, fail_count, err_count, num_cases);
		if (err_count == 0 && fail_count == 0 && !timed_out && num_cases > 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== verilog/tmu_edge_setup.sv ====
`timescale 1ns/1ps

module tmu_edge_setup(
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::tmu_triangle_t tri_i,

	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::tmu_div_result_t result_o,

	output logic busy_o
);

	// Sort to delta stage
	logic sort_stb;
	logic sort_ack;
	tmu_pkg::tmu_triangle_t sort_tri;
	logic sort_busy;

	// Delta stage to divider
	logic ops_stb;
	logic ops_ack;
	tmu_pkg::tmu_edges_t ops_edges;
	logic ops_busy;

	logic div_busy;

	tmu_vertex_sort vertex_sort_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.tri_i(tri_i),
		.pipe_stb_o(sort_stb),
		.pipe_ack_i(sort_ack),
		.tri_o(sort_tri),
		.busy_o(sort_busy)
	);

	tmu_edgedivops edgedivops_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(sort_stb),
		.pipe_ack_o(sort_ack),
		.tri_i(sort_tri),
		.pipe_stb_o(ops_stb),
		.pipe_ack_i(ops_ack),
		.edges_o(ops_edges),
		.busy_o(ops_busy)
	);

	// Divider acknowledge freezes both front stages while it works
	tmu_edgediv edgediv_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.pipe_stb_i(ops_stb),
		.pipe_ack_o(ops_ack),
		.edges_i(ops_edges),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.result_o(result_o),
		.busy_o(div_busy)
	);

	assign busy_o = sort_busy | ops_busy | div_busy;

endmodule

// ==== verilog/tmu_edgediv.sv ====
`timescale 1ns/1ps

module tmu_edgediv(
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::tmu_edges_t edges_i,

	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::tmu_div_result_t result_o,

	output logic busy_o
);

	tmu_pkg::tmu_div_state_e state;
	tmu_pkg::tmu_edges_t edges_q;
	logic [1:0] edge_cnt;
	logic [1:0] comp_cnt;
	logic [1:0] edge_nxt;
	logic [1:0] comp_nxt;
	logic [3:0] step_cnt;
	logic [3:0] res_idx;
	logic last_step;
	logic last_delta;
	logic [tmu_pkg::MAG_W-1:0] quo;
	logic [tmu_pkg::MAG_W-1:0] rem;
	logic [tmu_pkg::MAG_W-1:0] rem_next;
	logic [tmu_pkg::MAG_W-1:0] divisor_cur;
	logic [tmu_pkg::MAG_W:0] shifted;
	logic [tmu_pkg::MAG_W:0] trial;
	logic q_bit;
	logic rem_ok;

	// Dividend for one edge and component (0 dx, 1 du, 2 dv)
	function automatic logic [tmu_pkg::MAG_W-1:0] pick_mag(
		input tmu_pkg::tmu_edges_t e,
		input logic [1:0] edge_sel,
		input logic [1:0] comp_sel
	);
		case (comp_sel)
			2'd0: return e.edges[edge_sel].dx.mag;
			2'd1: return e.edges[edge_sel].du.mag;
			default: return e.edges[edge_sel].dv.mag;
		endcase
	endfunction

	// Restoring step: shift in the next dividend bit, try to subtract
	assign divisor_cur = edges_q.edges[edge_cnt].divisor;
	assign shifted = {rem, quo[tmu_pkg::MAG_W-1]};
	assign trial = shifted - {1'b0, divisor_cur};
	// No borrow means the subtraction fits
	assign q_bit = ~trial[tmu_pkg::MAG_W];
	assign rem_next = q_bit ? trial[tmu_pkg::MAG_W-1:0] : shifted[tmu_pkg::MAG_W-1:0];

	// Walk dx, du, dv of edge 1, then edge 2, then edge 3
	assign last_step = step_cnt == 4'(tmu_pkg::DIV_STEPS - 1);
	assign last_delta = (edge_cnt == 2'(tmu_pkg::NUM_EDGES - 1)) && (comp_cnt == 2'd2);
	assign comp_nxt = (comp_cnt == 2'd2) ? 2'd0 : comp_cnt + 2'd1;
	assign edge_nxt = (comp_cnt != 2'd2) ? edge_cnt :
		(edge_cnt == 2'(tmu_pkg::NUM_EDGES - 1)) ? 2'd0 : edge_cnt + 2'd1;
	assign res_idx = 4'(edge_cnt) * 4'd3 + 4'(comp_cnt);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::IDLE;
			edge_cnt <= '0;
			comp_cnt <= '0;
			step_cnt <= '0;
		end else begin
			case (state)
				tmu_pkg::IDLE: if (pipe_stb_i) state <= tmu_pkg::LOAD;
				tmu_pkg::LOAD: begin
					edge_cnt <= '0;
					comp_cnt <= '0;
					step_cnt <= '0;
					state <= tmu_pkg::DIVIDE;
				end
				tmu_pkg::DIVIDE: begin
					if (last_step) begin
						step_cnt <= '0;
						edge_cnt <= edge_nxt;
						comp_cnt <= comp_nxt;
						if (last_delta)
							state <= tmu_pkg::DONE;
					end else begin
						step_cnt <= step_cnt + 4'd1;
					end
				end
				// Hold the result until the consumer takes it
				default: if (pipe_ack_i) state <= tmu_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		case (state)
			// Capture on the transfer edge, the delta stage moves on right after
			tmu_pkg::IDLE: if (pipe_stb_i) edges_q <= edges_i;
			tmu_pkg::LOAD: begin
				quo <= pick_mag(edges_q, 2'd0, 2'd0);
				rem <= '0;
				for (int e = 0; e < tmu_pkg::NUM_EDGES; e++) begin
					result_o.positive[3*e] <= edges_q.edges[e].dx.positive;
					result_o.positive[3*e+1] <= edges_q.edges[e].du.positive;
					result_o.positive[3*e+2] <= edges_q.edges[e].dv.positive;
					result_o.divisor[e] <= edges_q.edges[e].divisor;
				end
				result_o.a_src <= edges_q.a_src;
				result_o.a_dst <= edges_q.a_dst;
				result_o.b_dst_y <= edges_q.b_dst_y;
				result_o.c_dst_y <= edges_q.c_dst_y;
			end
			tmu_pkg::DIVIDE: begin
				if (last_step) begin
					result_o.quotient[res_idx] <= {quo[tmu_pkg::MAG_W-2:0], q_bit};
					result_o.remainder[res_idx] <= rem_next;
					// Start the next dividend straight away
					quo <= pick_mag(edges_q, edge_nxt, comp_nxt);
					rem <= '0;
				end else begin
					quo <= {quo[tmu_pkg::MAG_W-2:0], q_bit};
					rem <= rem_next;
				end
			end
			default: ;
		endcase
	end

	assign pipe_ack_o = state == tmu_pkg::IDLE;
	assign pipe_stb_o = state == tmu_pkg::DONE;
	assign busy_o = state != tmu_pkg::IDLE;

	// Every remainder below the divisor of its own edge
	always_comb begin
		rem_ok = 1'b1;
		for (int e = 0; e < tmu_pkg::NUM_EDGES; e++)
			for (int k = 0; k < 3; k++)
				if (result_o.remainder[3*e+k] >= result_o.divisor[e])
					rem_ok = 1'b0;
	end

	a_rem_lt_div: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> rem_ok);

	a_hold_result: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable(result_o));

endmodule

// ==== verilog/tmu_edgedivops.sv ====
`timescale 1ns/1ps

module tmu_edgedivops(
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::tmu_triangle_t tri_i,

	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::tmu_edges_t edges_o,

	output logic busy_o
);

	logic valid_q;
	logic flat_ac;
	logic flat_bc;
	tmu_pkg::tmu_edges_t edges_d;

	// Sign and absolute difference, going from one coordinate to the other
	function automatic tmu_pkg::tmu_delta_t calc_delta(
		input logic signed [tmu_pkg::COORD_W-1:0] from_c,
		input logic signed [tmu_pkg::COORD_W-1:0] to_c
	);
		logic signed [tmu_pkg::COORD_W:0] diff;
		tmu_pkg::tmu_delta_t d;
		d.positive = to_c > from_c;
		if (d.positive)
			diff = to_c - from_c;
		else
			diff = from_c - to_c;
		// Out-of-range magnitudes are not clipped
		d.mag = diff[tmu_pkg::MAG_W-1:0];
		return d;
	endfunction

	// Y span of the edge, forced to 1 on a flat edge
	function automatic logic [tmu_pkg::MAG_W-1:0] calc_divisor(
		input logic signed [tmu_pkg::COORD_W-1:0] from_y,
		input logic signed [tmu_pkg::COORD_W-1:0] to_y
	);
		logic signed [tmu_pkg::COORD_W:0] span;
		span = to_y - from_y;
		if (span == '0)
			return tmu_pkg::MAG_W'(1);
		return span[tmu_pkg::MAG_W-1:0];
	endfunction

	assign flat_ac = tri_i.c.dst.y == tri_i.a.dst.y;
	assign flat_bc = tri_i.c.dst.y == tri_i.b.dst.y;

	always_comb begin
		// Edge 1, A to B, keeps its magnitudes even when flat
		edges_d.edges[0].dx = calc_delta(tri_i.a.dst.x, tri_i.b.dst.x);
		edges_d.edges[0].du = calc_delta(tri_i.a.src.x, tri_i.b.src.x);
		edges_d.edges[0].dv = calc_delta(tri_i.a.src.y, tri_i.b.src.y);
		edges_d.edges[0].divisor = calc_divisor(tri_i.a.dst.y, tri_i.b.dst.y);

		// Edge 2, A to C
		edges_d.edges[1].dx = calc_delta(tri_i.a.dst.x, tri_i.c.dst.x);
		edges_d.edges[1].du = calc_delta(tri_i.a.src.x, tri_i.c.src.x);
		edges_d.edges[1].dv = calc_delta(tri_i.a.src.y, tri_i.c.src.y);
		edges_d.edges[1].divisor = calc_divisor(tri_i.a.dst.y, tri_i.c.dst.y);

		// Edge 3, B to C
		edges_d.edges[2].dx = calc_delta(tri_i.b.dst.x, tri_i.c.dst.x);
		edges_d.edges[2].du = calc_delta(tri_i.b.src.x, tri_i.c.src.x);
		edges_d.edges[2].dv = calc_delta(tri_i.b.src.y, tri_i.c.src.y);
		edges_d.edges[2].divisor = calc_divisor(tri_i.b.dst.y, tri_i.c.dst.y);

		// Flat edges 2 and 3 are never stepped, so zero their dividends
		// (sign flags stay as computed)
		if (flat_ac) begin
			edges_d.edges[1].dx.mag = '0;
			edges_d.edges[1].du.mag = '0;
			edges_d.edges[1].dv.mag = '0;
		end
		if (flat_bc) begin
			edges_d.edges[2].dx.mag = '0;
			edges_d.edges[2].du.mag = '0;
			edges_d.edges[2].dv.mag = '0;
		end

		// Points needed later by the stepping stage
		edges_d.a_src = tri_i.a.src;
		edges_d.a_dst = tri_i.a.dst;
		edges_d.b_dst_y = tri_i.b.dst.y;
		edges_d.c_dst_y = tri_i.c.dst.y;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid_q <= 1'b0;
		else if (pipe_ack_i)
			valid_q <= pipe_stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (pipe_ack_i)
			edges_o <= edges_d;
	end

	assign pipe_ack_o = pipe_ack_i;
	assign pipe_stb_o = valid_q;
	assign busy_o = valid_q;

	a_divisor_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> (edges_o.edges[0].divisor != '0) && (edges_o.edges[1].divisor != '0)
			&& (edges_o.edges[2].divisor != '0));

endmodule

// ==== verilog/tmu_vertex_sort.sv ====
`timescale 1ns/1ps

module tmu_vertex_sort(
	input  logic sys_clk,
	input  logic sys_rst,

	input  logic pipe_stb_i,
	output logic pipe_ack_o,
	input  tmu_pkg::tmu_triangle_t tri_i,

	output logic pipe_stb_o,
	input  logic pipe_ack_i,
	output tmu_pkg::tmu_triangle_t tri_o,

	output logic busy_o
);

	logic b_lt_a;
	logic c_lt_a;
	logic c_lt_b;
	logic valid_q;
	tmu_pkg::tmu_triangle_t sorted;

	// Strict compares, so equal Y values never swap
	assign b_lt_a = tri_i.b.dst.y < tri_i.a.dst.y;
	assign c_lt_a = tri_i.c.dst.y < tri_i.a.dst.y;
	assign c_lt_b = tri_i.c.dst.y < tri_i.b.dst.y;

	// Pick the permutation from the three comparator outputs
	always_comb begin
		case ({b_lt_a, c_lt_a, c_lt_b})
			3'b001: sorted = '{a: tri_i.a, b: tri_i.c, c: tri_i.b};
			3'b011: sorted = '{a: tri_i.c, b: tri_i.a, c: tri_i.b};
			3'b100: sorted = '{a: tri_i.b, b: tri_i.a, c: tri_i.c};
			3'b110: sorted = '{a: tri_i.b, b: tri_i.c, c: tri_i.a};
			3'b111: sorted = '{a: tri_i.c, b: tri_i.b, c: tri_i.a};
			// Already in order; 010 and 101 cannot occur
			default: sorted = tri_i;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid_q <= 1'b0;
		else if (pipe_ack_i)
			valid_q <= pipe_stb_i;
	end

	// Payload follows the acknowledge, no reset needed
	always_ff @(posedge sys_clk) begin
		if (pipe_ack_i)
			tri_o <= sorted;
	end

	// Stage never stalls on its own
	assign pipe_ack_o = pipe_ack_i;
	assign pipe_stb_o = valid_q;
	assign busy_o = valid_q;

	a_sorted_out: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o |-> (tri_o.a.dst.y <= tri_o.b.dst.y) && (tri_o.b.dst.y <= tri_o.c.dst.y));

endmodule

// ==== verilog/tmu_pkg.sv ====
package tmu_pkg;

	// Coordinate format
	localparam int COORD_W = 12;
	localparam int MAG_W = 11;

	// Triangle has three edges, each with dx, du and dv
	localparam int NUM_EDGES = 3;
	localparam int NUM_DELTAS = 9;

	// One quotient bit per divider cycle
	localparam int DIV_STEPS = 11;

	typedef struct packed {
		logic signed [COORD_W-1:0] x;
		logic signed [COORD_W-1:0] y;
	} tmu_point_t;

	// Source is the texture point, destination the screen point
	typedef struct packed {
		tmu_point_t src;
		tmu_point_t dst;
	} tmu_vertex_t;

	typedef struct packed {
		tmu_vertex_t a;
		tmu_vertex_t b;
		tmu_vertex_t c;
	} tmu_triangle_t;

	// Direction flag plus absolute value
	typedef struct packed {
		logic positive;
		logic [MAG_W-1:0] mag;
	} tmu_delta_t;

	typedef struct packed {
		tmu_delta_t dx;
		tmu_delta_t du;
		tmu_delta_t dv;
		logic [MAG_W-1:0] divisor;
	} tmu_edge_t;

	// Index 0 is A to B, 1 is A to C, 2 is B to C
	typedef struct packed {
		tmu_edge_t [NUM_EDGES-1:0] edges;
		tmu_point_t a_src;
		tmu_point_t a_dst;
		logic signed [COORD_W-1:0] b_dst_y;
		logic signed [COORD_W-1:0] c_dst_y;
	} tmu_edges_t;

	// Delta index is 3*edge + component, component order dx, du, dv
	typedef struct packed {
		logic [NUM_DELTAS-1:0] positive;
		logic [NUM_DELTAS-1:0][MAG_W-1:0] quotient;
		logic [NUM_DELTAS-1:0][MAG_W-1:0] remainder;
		logic [NUM_EDGES-1:0][MAG_W-1:0] divisor;
		tmu_point_t a_src;
		tmu_point_t a_dst;
		logic signed [COORD_W-1:0] b_dst_y;
		logic signed [COORD_W-1:0] c_dst_y;
	} tmu_div_result_t;

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		DIVIDE,
		DONE
	} tmu_div_state_e;

endpackage
